// File: include/vga_fb_mode.svh
`ifndef VGA_FB_MODE_SVH
`define VGA_FB_MODE_SVH

// picks which video mode the package builds in
// 1 selects the tiny raster that lets whole frames simulate in a few hundred cycles
// 0 selects the standard 640x480 timing
`define VGA_FB_MODE_SMALL 1

`endif

// File: src/vga_fb_pkg.sv
`include "vga_fb_mode.svh"

package vga_fb_pkg;

  localparam bit mode_small = `VGA_FB_MODE_SMALL;

  // horizontal timing, counted in pixel positions
  localparam int h_visible     = mode_small ? 8 : 640;
  localparam int h_front_porch = mode_small ? 2 : 16;
  localparam int h_sync_pulse  = mode_small ? 3 : 96;
  localparam int h_back_porch  = mode_small ? 3 : 48;
  localparam int h_whole_line  = h_visible + h_front_porch + h_sync_pulse + h_back_porch;
  localparam int h_sync_start  = h_visible + h_front_porch;
  localparam int h_sync_end    = h_sync_start + h_sync_pulse;

  // vertical timing, counted in lines
  localparam int v_visible     = mode_small ? 6 : 480;
  localparam int v_front_porch = mode_small ? 1 : 10;
  localparam int v_sync_pulse  = mode_small ? 2 : 2;
  localparam int v_back_porch  = mode_small ? 1 : 33;
  localparam int v_whole_frame = v_visible + v_front_porch + v_sync_pulse + v_back_porch;
  localparam int v_sync_start  = v_visible + v_front_porch;
  localparam int v_sync_end    = v_sync_start + v_sync_pulse;

  // counter and frame buffer sizes
  localparam int x_bits       = $clog2(h_whole_line);
  localparam int y_bits       = $clog2(v_whole_frame);
  localparam int fb_depth     = h_visible * v_visible;
  localparam int fb_addr_bits = $clog2(fb_depth);
  localparam int fb_data_bits = 16;
  localparam int color_bits   = 4;

  // pixel context carried from request to response, packed as {visible, vsync, hsync}
  localparam int ctx_bits       = 3;
  localparam int ctx_visible    = 2;
  localparam int ctx_vsync      = 1;
  localparam int ctx_hsync      = 0;
  localparam int ctx_fifo_depth = 8;
  localparam int ctx_ptr_bits   = $clog2(ctx_fifo_depth);

  // read state machine encoding
  localparam logic stream_idle    = 1'b0;
  localparam logic stream_reading = 1'b1;

  localparam logic [1:0] axi_resp_okay = 2'b00;

  // the frame buffer keeps color in the top 12 bits and pads the bottom
  typedef struct packed {
    logic [color_bits-1:0]                red;
    logic [color_bits-1:0]                grn;
    logic [color_bits-1:0]                blu;
    logic [fb_data_bits-3*color_bits-1:0] pad;
  } fb_color_t;

  typedef union packed {
    logic [fb_data_bits-1:0] raw;
    fb_color_t               color;
  } fb_word_u;

endpackage

// File: src/vga_raster_timing.sv
`timescale 1ns/1ps

module vga_raster_timing
  import vga_fb_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              advance,
  output logic              visible,
  output logic              hsync,
  output logic              vsync,
  output logic [x_bits-1:0] column,
  output logic [y_bits-1:0] row
);

  logic line_end;
  logic frame_end;
  logic in_hsync;
  logic in_vsync;

  // the last position of a line and the last line of a frame
  assign line_end  = column == x_bits'(h_whole_line - 1);
  assign frame_end = row == y_bits'(v_whole_frame - 1);

  // the counters only move when the streamer has taken the current position,
  // so the raster runs at whatever pace the consumer allows
  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
      row    <= '0;
    end else if (advance) begin
      if (line_end) begin
        column <= '0;
        if (frame_end) begin
          row <= '0;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  // visible area sits in the top left corner of the whole raster
  assign visible = (column < x_bits'(h_visible)) && (row < y_bits'(v_visible));

  // the sync windows start right after the front porches
  assign in_hsync = (column >= x_bits'(h_sync_start)) && (column < x_bits'(h_sync_end));
  assign in_vsync = (row >= y_bits'(v_sync_start)) && (row < y_bits'(v_sync_end));

  // both pulses are active low and idle high
  assign hsync = !in_hsync;
  assign vsync = !in_vsync;

endmodule

// File: src/pixel_context_fifo.sv
`timescale 1ns/1ps

module pixel_context_fifo
  import vga_fb_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                write_en,
  input  logic                read_en,
  input  logic [ctx_bits-1:0] write_data,
  output logic [ctx_bits-1:0] read_data,
  output logic                empty,
  output logic                full
);

  logic [ctx_bits-1:0]     mem [ctx_fifo_depth];
  logic [ctx_ptr_bits-1:0] wr_ptr;
  logic [ctx_ptr_bits-1:0] rd_ptr;
  logic [ctx_ptr_bits-1:0] rd_ptr_next;
  logic [ctx_ptr_bits:0]   count;
  logic                    load_direct;

  // depth is a power of two so the pointers wrap on their own
  assign rd_ptr_next = rd_ptr + 1'b1;
  assign empty       = count == '0;
  assign full        = count == (ctx_ptr_bits + 1)'(ctx_fifo_depth);

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[wr_ptr] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (write_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (read_en) begin
        rd_ptr <= rd_ptr_next;
      end
      case ({write_en, read_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read_data always shows the head entry so the streamer can decide on a pop
  // in the same cycle. a write into an empty fifo, or into one that is about
  // to go empty, bypasses the array
  assign load_direct = write_en && (empty || (read_en && count == 1));

  always_ff @(posedge clk) begin
    if (load_direct) begin
      read_data <= write_data;
    end else if (read_en) begin
      read_data <= mem[rd_ptr_next];
    end
  end

  // the streamer paces itself off the raster, it never looks at full
  assert property (@(posedge clk) disable iff (reset) write_en |-> !full)
    else $error("pixel context pushed into a full fifo");

  assert property (@(posedge clk) disable iff (reset) read_en |-> !empty)
    else $error("pixel context popped from an empty fifo");

endmodule

// File: src/fb_sram.sv
`timescale 1ns/1ps

module fb_sram
  import vga_fb_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // plain load port for the frame contents
  input  logic                    fb_wr_en,
  input  logic [fb_addr_bits-1:0] fb_wr_addr,
  input  logic [fb_data_bits-1:0] fb_wr_data,

  // axi read address channel, this side is the slave
  input  logic [fb_addr_bits-1:0] ar_addr,
  input  logic                    ar_valid,
  output logic                    ar_ready,

  // axi read data channel
  output logic [fb_data_bits-1:0] r_data,
  output logic                    r_valid,
  output logic [1:0]              r_resp
);

  logic [fb_data_bits-1:0] mem [fb_depth];
  logic                    read_accepted;

  // the array is single cycle so an address is never refused
  assign ar_ready      = 1'b1;
  assign read_accepted = ar_valid && ar_ready;

  always_ff @(posedge clk) begin
    if (fb_wr_en) begin
      mem[fb_wr_addr] <= fb_wr_data;
    end
  end

  // a read and a write to the same word in one cycle return the old word,
  // since both happen on the same edge
  always_ff @(posedge clk) begin
    if (read_accepted) begin
      r_data <= mem[ar_addr];
    end
  end

  // response follows acceptance by exactly one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= read_accepted;
    end
  end

  // there is no error path in a plain array
  assign r_resp = axi_resp_okay;

  // the streamer only reads inside the visible area, which maps onto the array
  assert property (@(posedge clk) disable iff (reset)
    read_accepted |-> ar_addr < fb_addr_bits'(fb_depth))
    else $error("frame buffer read outside the visible area");

endmodule

// File: src/fb_pixel_stream.sv
`timescale 1ns/1ps

module fb_pixel_stream
  import vga_fb_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // stream toward the downstream pixel fifo
  input  logic                    enable,
  output logic                    valid,
  output logic                    hsync,
  output logic                    vsync,
  output logic [color_bits-1:0]   red,
  output logic [color_bits-1:0]   grn,
  output logic [color_bits-1:0]   blu,

  // raster timing side
  output logic                    advance,
  input  logic                    pos_visible,
  input  logic                    pos_hsync,
  input  logic                    pos_vsync,
  input  logic [x_bits-1:0]       column,
  input  logic [y_bits-1:0]       row,

  // pixel context fifo side
  output logic                    ctx_push,
  output logic                    ctx_pop,
  output logic [ctx_bits-1:0]     ctx_wdata,
  input  logic [ctx_bits-1:0]     ctx_rdata,
  input  logic                    ctx_empty,

  // axi read master toward the frame buffer
  output logic [fb_addr_bits-1:0] ar_addr,
  output logic                    ar_valid,
  input  logic                    ar_ready,
  input  logic [fb_data_bits-1:0] r_data,
  input  logic                    r_valid,
  output logic                    r_ready,
  input  logic [1:0]              r_resp
);

  logic                    state;
  logic                    next_state;
  logic                    read_start;
  logic                    read_accepted;
  logic                    read_done;
  logic [fb_addr_bits-1:0] addr_calc;
  logic                    head_visible;
  fb_word_u                pixel_word;

  assign read_accepted = ar_valid && ar_ready;
  assign read_done     = r_valid && r_ready;

  // linear address of the current position, only meaningful while visible
  assign addr_calc = fb_addr_bits'(row) * fb_addr_bits'(h_visible) + fb_addr_bits'(column);

  // one read in flight on the address channel at a time. a new one is
  // started in the cycle the previous address is taken, so the channel
  // stays busy across a whole visible line
  always_comb begin
    next_state = state;
    read_start = 1'b0;
    case (state)
      stream_idle: begin
        // blanking positions never touch the memory
        if (enable && pos_visible) begin
          read_start = 1'b1;
          next_state = stream_reading;
        end
      end
      stream_reading: begin
        if (read_accepted) begin
          if (enable && pos_visible) begin
            read_start = 1'b1;
          end else begin
            next_state = stream_idle;
          end
        end
      end
      default: next_state = stream_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stream_idle;
    end else begin
      state <= next_state;
    end
  end

  // a position is taken either by a read or by simply passing over blanking
  assign advance = read_start || (!pos_visible && enable);

  // every taken position leaves its context in the fifo, in raster order
  assign ctx_push  = advance;
  assign ctx_wdata = {pos_visible, pos_vsync, pos_hsync};

  // _p1 stage, the address is captured with the read and held until accepted
  always_ff @(posedge clk) begin
    if (read_start) begin
      ar_addr <= addr_calc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ar_valid <= 1'b0;
    end else if (read_start) begin
      ar_valid <= 1'b1;
    end else if (read_accepted) begin
      ar_valid <= 1'b0;
    end
  end

  // data is always welcome here
  always_ff @(posedge clk) begin
    if (reset) begin
      r_ready <= 1'b1;
    end
  end

  // blanking heads drain at once, a visible head waits for its word. reads
  // come back in order, so the returned word belongs to the head
  assign head_visible = ctx_rdata[ctx_visible];
  assign ctx_pop      = !ctx_empty && (!head_visible || read_done);

  assign pixel_word.raw = r_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
      hsync <= 1'b1;
      vsync <= 1'b1;
      red   <= '0;
      grn   <= '0;
      blu   <= '0;
    end else begin
      valid <= ctx_pop;
      if (ctx_pop) begin
        hsync <= ctx_rdata[ctx_hsync];
        vsync <= ctx_rdata[ctx_vsync];
        // black outside the visible area
        red   <= head_visible ? pixel_word.color.red : '0;
        grn   <= head_visible ? pixel_word.color.grn : '0;
        blu   <= head_visible ? pixel_word.color.blu : '0;
      end
    end
  end

  // the address may not be withdrawn or changed until the memory takes it
  assert property (@(posedge clk) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else $error("read address dropped before acceptance");

  // each returned word must meet a visible context already at the fifo head
  assert property (@(posedge clk) disable iff (reset)
    read_done |-> !ctx_empty && head_visible && r_resp == axi_resp_okay)
    else $error("read data arrived without a matching visible context");

endmodule

// File: src/vga_fb_top.sv
`timescale 1ns/1ps

module vga_fb_top
  import vga_fb_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    fb_wr_en,
  input  logic [fb_addr_bits-1:0] fb_wr_addr,
  input  logic [fb_data_bits-1:0] fb_wr_data,
  output logic                    valid,
  output logic                    hsync,
  output logic                    vsync,
  output logic [color_bits-1:0]   red,
  output logic [color_bits-1:0]   grn,
  output logic [color_bits-1:0]   blu
);

  logic                    advance;
  logic                    pos_visible;
  logic                    pos_hsync;
  logic                    pos_vsync;
  logic [x_bits-1:0]       column;
  logic [y_bits-1:0]       row;
  logic                    ctx_push;
  logic                    ctx_pop;
  logic [ctx_bits-1:0]     ctx_wdata;
  logic [ctx_bits-1:0]     ctx_rdata;
  logic                    ctx_empty;
  logic [fb_addr_bits-1:0] ar_addr;
  logic                    ar_valid;
  logic                    ar_ready;
  logic [fb_data_bits-1:0] r_data;
  logic                    r_valid;
  logic [1:0]              r_resp;

  // the ram answers every accepted read one cycle later and never needs
  // r_ready, and the streamer stays far below the fifo depth
  fb_pixel_stream fb_pixel_stream_inst (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .valid       (valid),
    .hsync       (hsync),
    .vsync       (vsync),
    .red         (red),
    .grn         (grn),
    .blu         (blu),
    .advance     (advance),
    .pos_visible (pos_visible),
    .pos_hsync   (pos_hsync),
    .pos_vsync   (pos_vsync),
    .column      (column),
    .row         (row),
    .ctx_push    (ctx_push),
    .ctx_pop     (ctx_pop),
    .ctx_wdata   (ctx_wdata),
    .ctx_rdata   (ctx_rdata),
    .ctx_empty   (ctx_empty),
    .ar_addr     (ar_addr),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r_data      (r_data),
    .r_valid     (r_valid),
    .r_ready     (),
    .r_resp      (r_resp)
  );

  vga_raster_timing vga_raster_timing_inst (
    .clk     (clk),
    .reset   (reset),
    .advance (advance),
    .visible (pos_visible),
    .hsync   (pos_hsync),
    .vsync   (pos_vsync),
    .column  (column),
    .row     (row)
  );

  pixel_context_fifo pixel_context_fifo_inst (
    .clk        (clk),
    .reset      (reset),
    .write_en   (ctx_push),
    .read_en    (ctx_pop),
    .write_data (ctx_wdata),
    .read_data  (ctx_rdata),
    .empty      (ctx_empty),
    .full       ()
  );

  fb_sram fb_sram_inst (
    .clk        (clk),
    .reset      (reset),
    .fb_wr_en   (fb_wr_en),
    .fb_wr_addr (fb_wr_addr),
    .fb_wr_data (fb_wr_data),
    .ar_addr    (ar_addr),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r_data     (r_data),
    .r_valid    (r_valid),
    .r_resp     (r_resp)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int period_ns        = 40;
  localparam int reset_cycles     = 5;
  // reset is released a little after the edge, like every other input
  localparam int release_delay_ns = 2;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #(release_delay_ns);
    reset = 1'b0;
  end

endmodule

// File: tests/vga_fb_tb.sv
`timescale 1ns/1ps

module vga_fb_tb
  import vga_fb_pkg::*;
();

  localparam int drive_delay     = 2;
  localparam int line_len        = h_visible + h_front_porch + h_sync_pulse + h_back_porch;
  localparam int frame_lines     = v_visible + v_front_porch + v_sync_pulse + v_back_porch;
  localparam int frame_positions = line_len * frame_lines;
  localparam int total_positions = 4 * frame_positions;
  // the rewrite starts in row 7 of the third frame where the raster is blanked
  localparam int rewrite_point   = 2 * frame_positions + (v_visible + v_front_porch) * line_len;
  // the watchdog allows three frames at four cycles per position
  localparam int watchdog_cycles = 3 * frame_positions * 4;

  logic                    clk;
  logic                    reset;
  logic                    enable;
  logic                    fb_wr_en;
  logic [fb_addr_bits-1:0] fb_wr_addr;
  logic [fb_data_bits-1:0] fb_wr_data;
  logic                    valid;
  logic                    hsync;
  logic                    vsync;
  logic [color_bits-1:0]   red;
  logic [color_bits-1:0]   grn;
  logic [color_bits-1:0]   blu;

  // the model of the frame buffer is updated together with every write
  logic [fb_data_bits-1:0]   fb_model [fb_depth];
  logic [31:0]               rng_state;
  logic [3*color_bits+1:0]   expected_out;
  int                        checked_count = 0;

  tb_clock_gen tb_clock_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  vga_fb_top vga_fb_top_inst (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .fb_wr_en   (fb_wr_en),
    .fb_wr_addr (fb_wr_addr),
    .fb_wr_data (fb_wr_data),
    .valid      (valid),
    .hsync      (hsync),
    .vsync      (vsync),
    .red        (red),
    .grn        (grn),
    .blu        (blu)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected {red, grn, blu, hsync, vsync} for the nth raster position since reset
  function automatic logic [3*color_bits+1:0] expected_pixel(
    input int                      index,
    input logic [fb_data_bits-1:0] fb [fb_depth]
  );
    int                      column;
    int                      row;
    logic                    vis;
    logic                    hs;
    logic                    vs;
    logic [fb_data_bits-1:0] word;
    column = index % line_len;
    row    = (index / line_len) % frame_lines;
    vis    = (column < h_visible) && (row < v_visible);
    // sync pulses are low right after the front porch
    hs = !((column >= h_visible + h_front_porch) &&
           (column < h_visible + h_front_porch + h_sync_pulse));
    vs = !((row >= v_visible + v_front_porch) &&
           (row < v_visible + v_front_porch + v_sync_pulse));
    word = '0;
    if (vis) begin
      word = fb[fb_addr_bits'(row * h_visible + column)];
    end
    // the color fields sit in the top twelve bits with red highest
    return {word[15:12], word[11:8], word[7:4], hs, vs};
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] want);
    if (actual !== want) begin
      $display("FAILED at %0t: %s after %0d positions, got 0x%0h, expected 0x%0h",
               $time, what, checked_count, actual, want);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // fills the whole frame buffer with random words at one write per cycle
  task automatic load_frame();
    for (int a = 0; a < fb_depth; a++) begin
      rng_state = xorshift32(rng_state);
      fb_model[fb_addr_bits'(a)] = rng_state[fb_data_bits-1:0];
      fb_wr_en   = 1'b1;
      fb_wr_addr = fb_addr_bits'(a);
      fb_wr_data = rng_state[fb_data_bits-1:0];
      @(posedge clk);
      #drive_delay;
    end
    fb_wr_en = 1'b0;
  endtask

  // returns a little after the first edge at which enough strobes were checked
  task automatic wait_for_positions(input int target);
    do begin
      @(posedge clk);
    end while (checked_count < target);
    #drive_delay;
  endtask

  // outputs are registered on the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    if (!reset && valid) begin
      expected_out = expected_pixel(checked_count, fb_model);
      check_value("red", 32'(red), 32'(expected_out[13:10]));
      check_value("green", 32'(grn), 32'(expected_out[9:6]));
      check_value("blue", 32'(blu), 32'(expected_out[5:2]));
      check_value("hsync", 32'(hsync), 32'(expected_out[1]));
      check_value("vsync", 32'(vsync), 32'(expected_out[0]));
      checked_count++;
    end
  end

  initial begin
    enable     = 1'b0;
    fb_wr_en   = 1'b0;
    fb_wr_addr = '0;
    fb_wr_data = '0;
    rng_state  = 32'h7f91adff;
    @(negedge reset);

    // quiet outputs while nothing is enabled
    repeat (6) begin
      @(negedge clk);
      check_value("valid while idle", 32'(valid), 32'd0);
      check_value("hsync while idle", 32'(hsync), 32'd1);
      check_value("vsync while idle", 32'(vsync), 32'd1);
      check_value("color while idle", 32'({red, grn, blu}), 32'd0);
    end
    @(posedge clk);
    #drive_delay;
    load_frame();

    // one whole frame at a steady enable
    enable = 1'b1;
    wait_for_positions(frame_positions);

    // a frame with a random enable must give the same sequence
    while (checked_count < 2 * frame_positions) begin
      rng_state = xorshift32(rng_state);
      enable    = rng_state[0];
      @(posedge clk);
      #drive_delay;
    end
    enable = 1'b1;

    // hold the raster in the vertical blanking and load a new frame there
    wait_for_positions(rewrite_point);
    enable = 1'b0;
    load_frame();
    enable = 1'b1;
    wait_for_positions(total_positions);

    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the pixel stream stalled, %0d of %0d positions arrived",
             checked_count, total_positions);
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

// File: vga_fb_top.f
+incdir+include
src/vga_fb_pkg.sv
src/vga_raster_timing.sv
src/pixel_context_fifo.sv
src/fb_sram.sv
src/fb_pixel_stream.sv
src/vga_fb_top.sv
tests/tb_clock_gen.sv
tests/vga_fb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vga_fb_tb
FILELIST  ?= vga_fb_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
